// ==== hw/router_defs.svh ====
// Shared sizes for the request router; the last port is always the uplink
`ifndef ROUTER_DEFS_SVH
`define ROUTER_DEFS_SVH

// --------------------
// Port and bus widths
// --------------------

// Destination ports, uplink included
`define ROUTER_NUM_PORTS 4

`define ROUTER_ADDR_W 32
`define ROUTER_DATA_W 32

// --------------------
// Request FIFO
// --------------------

// Must be a power of two
`define ROUTER_FIFO_DEPTH 16

// Fill level that raises prog_full, keep below depth minus in-flight stages
`define ROUTER_PROG_THRESH 12

// Cycles after reset during which the FIFO refuses traffic
`define ROUTER_RST_BUSY_CYCLES 4

`endif

// ==== hw/fifo_pkg.sv ====
// FIFO status flags seen upstream and the config register map; addresses are word indices
package fifo_pkg;

  // --------------------
  // FIFO status
  // --------------------

  // Setup is high while the FIFO is coming out of reset
  typedef struct packed {
    logic full;
    logic prog_full;
    logic empty;
    logic setup;
  } fifo_state_t;

  // --------------------
  // Config registers
  // --------------------

  // DROP_COUNT is read-only
  typedef enum logic [1:0] {
    LOCAL_BUNDLE = 2'd0,
    FORWARD_EN   = 2'd1,
    DROP_COUNT   = 2'd2
  } cfg_addr_e;

endpackage : fifo_pkg

// ==== hw/pkt_pkg.sv ====
// Memory request packet layout; bundle ids and lane masks are one bit per router port
`include "router_defs.svh"

package pkt_pkg;

  // --------------------
  // Route metadata
  // --------------------

  // Bundle is one-hot, lane may name several lanes for multicast
  typedef struct packed {
    logic [`ROUTER_NUM_PORTS-1:0] bundle;
    logic [`ROUTER_NUM_PORTS-1:0] lane;
  } route_t;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

  // --------------------
  // Packet
  // --------------------

  typedef struct packed {
    route_t                    route;
    mem_cmd_e                  cmd;
    logic [`ROUTER_ADDR_W-1:0] addr;
    logic [`ROUTER_DATA_W-1:0] data;
  } payload_t;

  typedef struct packed {
    logic     valid;
    payload_t payload;
  } mem_packet_t;

endpackage : pkt_pkg

// ==== hw/sync_fifo_fwft.sv ====
// FWFT FIFO for payloads; DEPTH must be a power of two and pushes while full or busy are lost
`include "router_defs.svh"

module sync_fifo_fwft #(
  parameter int DEPTH = `ROUTER_FIFO_DEPTH
) (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  input  pkt_pkg::payload_t     din,
  input  logic                  push,
  input  logic                  pop,
  output pkt_pkg::payload_t     dout,
  output logic                  head_valid,
  output fifo_pkg::fifo_state_t state
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = AW + 1;
  localparam int BW = $clog2(`ROUTER_RST_BUSY_CYCLES + 1);

  pkt_pkg::payload_t mem [DEPTH];

  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic [BW-1:0] busy_cnt;
  logic          busy;
  logic          wr_fire;
  logic          rd_fire;

  // --------------------
  // Reset-busy window
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      busy_cnt <= BW'(`ROUTER_RST_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  assign busy = (busy_cnt != '0);

  // --------------------
  // Flags
  // --------------------

  assign state.full      = (count == CW'(DEPTH));
  assign state.prog_full = (count >= CW'(`ROUTER_PROG_THRESH));
  assign state.empty     = (count == '0);
  assign state.setup     = busy;

  assign wr_fire = push & ~state.full & ~busy;
  assign rd_fire = pop & ~state.empty & ~busy;

  // --------------------
  // Pointers and storage
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_fire) wr_ptr <= wr_ptr + 1'b1;
      if (rd_fire) rd_ptr <= rd_ptr + 1'b1;
      // Simultaneous push and pop leaves the level unchanged
      if (wr_fire && !rd_fire) begin
        count <= count + 1'b1;
      end else if (rd_fire && !wr_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (wr_fire) mem[wr_ptr] <= din;
  end

  // Head is shown as soon as it is written
  assign dout       = mem[rd_ptr];
  assign head_valid = ~state.empty & ~busy;

  // Upstream stalls on prog_full, so a push never meets a full FIFO
  assert property (@(posedge ap_clk) disable iff (areset_control)
    push && !busy |-> !state.full)
    else $error("Push arrived while the FIFO is full");

endmodule : sync_fifo_fwft

// ==== hw/request_demux.sv ====
// 1-to-N request router; upstream must stall on prog_full or setup, multicast waits for all lanes
`include "router_defs.svh"

module request_demux (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  pkt_pkg::mem_packet_t         request_in,
  output fifo_pkg::fifo_state_t        request_status,
  output pkt_pkg::mem_packet_t         request_out [`ROUTER_NUM_PORTS-1:0],
  input  logic [`ROUTER_NUM_PORTS-1:0] dest_ready,
  input  logic [`ROUTER_NUM_PORTS-1:0] local_bundle,
  input  logic                         forward_en,
  output logic                         drop_pulse
);

  localparam int N = `ROUTER_NUM_PORTS;

  pkt_pkg::mem_packet_t  in_reg;
  logic                  in_fwd;
  logic                  push;

  pkt_pkg::payload_t     head;
  logic                  head_valid;
  logic                  head_fwd;
  fifo_pkg::fifo_state_t fifo_state;

  logic [N-1:0]          ready_reg;
  logic [N-1:0]          ready_mask;
  logic                  lanes_ready;
  logic                  pop;

  pkt_pkg::mem_packet_t  pop_reg;
  logic                  pop_fwd_reg;

  // --------------------
  // Input stage
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      in_reg.valid <= 1'b0;
    end else begin
      in_reg.valid <= request_in.valid;
    end
  end

  always_ff @(posedge ap_clk) begin
    in_reg.payload <= request_in.payload;
  end

  // Foreign bundle goes to the uplink only when forwarding is on
  assign in_fwd = forward_en & (in_reg.payload.route.bundle != local_bundle);

  assign push       = in_reg.valid & ((|in_reg.payload.route.lane) | in_fwd);
  assign drop_pulse = in_reg.valid & ~(|in_reg.payload.route.lane) & ~in_fwd;

  sync_fifo_fwft #(
    .DEPTH(`ROUTER_FIFO_DEPTH)
  ) u_fifo (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .din           (in_reg.payload),
    .push          (push),
    .pop           (pop),
    .dout          (head),
    .head_valid    (head_valid),
    .state         (fifo_state)
  );

  assign request_status = fifo_state;

  // --------------------
  // Readiness and pop
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ready_reg <= '0;
    end else begin
      ready_reg <= dest_ready;
    end
  end

  assign ready_mask  = ready_reg & head.route.lane;
  assign lanes_ready = (ready_mask == head.route.lane);
  assign head_fwd    = forward_en & (head.route.bundle != local_bundle);

  // Every named lane ready in the same cycle, or the head leaves on the uplink
  assign pop = head_valid & (lanes_ready | head_fwd);

  // --------------------
  // Output stages
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      pop_reg.valid <= 1'b0;
      pop_fwd_reg   <= 1'b0;
    end else begin
      pop_reg.valid <= pop;
      pop_fwd_reg   <= head_fwd;
    end
  end

  always_ff @(posedge ap_clk) begin
    pop_reg.payload <= head;
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      for (int i = 0; i < N; i++) begin
        request_out[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < N; i++) begin
        if (pop_fwd_reg) begin
          request_out[i].valid <= pop_reg.valid & (i == N - 1);
        end else begin
          request_out[i].valid <= pop_reg.valid & pop_reg.payload.route.lane[i];
        end
      end
    end
  end

  // Same payload on every port, valid picks the receivers
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < N; i++) begin
      request_out[i].payload <= pop_reg.payload;
    end
  end

  // A port outside the lanes fires only as the uplink of a foreign bundle
  for (genvar g = 0; g < N; g++) begin : g_port_chk
    assert property (@(posedge ap_clk) disable iff (areset_control)
      request_out[g].valid |-> (request_out[g].payload.route.lane[g] ||
        (g == N - 1 && forward_en &&
         request_out[g].payload.route.bundle != local_bundle)))
      else $error("Output valid on port %0d outside the packet lanes", g);
  end

  // A head can only be there if it was pushed or the FIFO already held one
  assert property (@(posedge ap_clk) disable iff (areset_control)
    pop |-> ($past(push) || !$past(fifo_state.empty)))
    else $error("Pop while the request FIFO is empty");

endmodule : request_demux

// ==== hw/route_config_regs.sv ====
// Four-phase config port; requester must not raise req while ack is high, drop count saturates
`include "router_defs.svh"

module route_config_regs (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  logic                         cfg_req,
  input  logic                         cfg_we,
  input  fifo_pkg::cfg_addr_e          cfg_addr,
  input  logic [31:0]                  cfg_wdata,
  output logic                         cfg_ack,
  output logic [31:0]                  cfg_rdata,
  input  logic                         drop_pulse,
  output logic [`ROUTER_NUM_PORTS-1:0] local_bundle,
  output logic                         forward_en
);

  typedef enum logic {
    ACK_IDLE = 1'b0,
    ACK_HIGH = 1'b1
  } ack_state_e;

  ack_state_e  ack_state;
  logic [31:0] drop_count;

  // --------------------
  // Handshake and access
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      ack_state    <= ACK_IDLE;
      local_bundle <= `ROUTER_NUM_PORTS'(1);
      forward_en   <= 1'b0;
    end else begin
      case (ack_state)
        ACK_IDLE: begin
          if (cfg_req) begin
            ack_state <= ACK_HIGH;
            if (cfg_we && cfg_addr == fifo_pkg::LOCAL_BUNDLE) begin
              local_bundle <= cfg_wdata[`ROUTER_NUM_PORTS-1:0];
            end
            if (cfg_we && cfg_addr == fifo_pkg::FORWARD_EN) begin
              forward_en <= cfg_wdata[0];
            end
          end
        end
        default: begin
          if (!cfg_req) ack_state <= ACK_IDLE;
        end
      endcase
    end
  end

  // Read data latched at the access, held while ack is up
  always_ff @(posedge ap_clk) begin
    if (ack_state == ACK_IDLE && cfg_req) begin
      case (cfg_addr)
        fifo_pkg::LOCAL_BUNDLE: cfg_rdata <= 32'(local_bundle);
        fifo_pkg::FORWARD_EN:   cfg_rdata <= 32'(forward_en);
        fifo_pkg::DROP_COUNT:   cfg_rdata <= drop_count;
        default:                cfg_rdata <= '0;
      endcase
    end
  end

  assign cfg_ack = (ack_state == ACK_HIGH);

  // --------------------
  // Drop counter
  // --------------------

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      drop_count <= '0;
    end else if (drop_pulse && drop_count != '1) begin
      drop_count <= drop_count + 1'b1;
    end
  end

  // Req is still held when ack comes up
  assert property (@(posedge ap_clk) disable iff (areset_control)
    $rose(cfg_ack) |-> cfg_req)
    else $error("Config ack rose without a request");

endmodule : route_config_regs

// ==== hw/request_router_top.sv ====
// Request router top; config registers steer the demux, the last request port is the uplink
`include "router_defs.svh"

module request_router_top (
  input  logic                         ap_clk,
  input  logic                         areset_control,
  input  pkt_pkg::mem_packet_t         request_in,
  output fifo_pkg::fifo_state_t        request_status,
  output pkt_pkg::mem_packet_t         request_out [`ROUTER_NUM_PORTS-1:0],
  input  logic [`ROUTER_NUM_PORTS-1:0] dest_ready,
  input  logic                         cfg_req,
  input  logic                         cfg_we,
  input  fifo_pkg::cfg_addr_e          cfg_addr,
  input  logic [31:0]                  cfg_wdata,
  output logic                         cfg_ack,
  output logic [31:0]                  cfg_rdata
);

  logic [`ROUTER_NUM_PORTS-1:0] local_bundle;
  logic                         forward_en;
  logic                         drop_pulse;

  route_config_regs u_regs (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .cfg_req       (cfg_req),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_ack       (cfg_ack),
    .cfg_rdata     (cfg_rdata),
    .drop_pulse    (drop_pulse),
    .local_bundle  (local_bundle),
    .forward_en    (forward_en)
  );

  request_demux u_demux (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (request_in),
    .request_status(request_status),
    .request_out   (request_out),
    .dest_ready    (dest_ready),
    .local_bundle  (local_bundle),
    .forward_en    (forward_en),
    .drop_pulse    (drop_pulse)
  );

endmodule : request_router_top

// ==== testbench/request_router_tb.sv ====
// Testbench for the request router; table rows assume 4 ports with port 3 as the uplink
`include "router_defs.svh"

module request_router_tb;

  localparam int N       = `ROUTER_NUM_PORTS;
  localparam int ROWS    = 9;
  localparam int TIMEOUT = 40;

  typedef struct packed {
    logic [N-1:0] bundle;
    logic [N-1:0] lane;
    logic [N-1:0] ready;
    logic [N-1:0] local_id;
    logic         fwd;
    logic [N-1:0] exp_mask;
  } row_t;

  logic                  ap_clk;
  logic                  areset_control;
  pkt_pkg::mem_packet_t  request_in;
  fifo_pkg::fifo_state_t request_status;
  pkt_pkg::mem_packet_t  request_out [N-1:0];
  logic [N-1:0]          dest_ready;
  logic                  cfg_req;
  logic                  cfg_we;
  fifo_pkg::cfg_addr_e   cfg_addr;
  logic [31:0]           cfg_wdata;
  logic                  cfg_ack;
  logic [31:0]           cfg_rdata;
  logic [15:0]           lfsr_state;
  int                    expected_drops;

  // Bundle, lane, ready, local bundle, forward enable, expected ports (empty means drop)
  row_t rows [ROWS] = '{
    '{4'b0001, 4'b0010, 4'b1111, 4'b0001, 1'b0, 4'b0010},
    '{4'b0001, 4'b0100, 4'b1111, 4'b0001, 1'b0, 4'b0100},
    '{4'b0001, 4'b0111, 4'b1101, 4'b0001, 1'b0, 4'b0111},
    '{4'b0100, 4'b0011, 4'b0000, 4'b0001, 1'b1, 4'b1000},
    '{4'b0100, 4'b0011, 4'b1111, 4'b0001, 1'b0, 4'b0011},
    '{4'b0001, 4'b0000, 4'b1111, 4'b0001, 1'b0, 4'b0000},
    '{4'b0010, 4'b0000, 4'b1111, 4'b0010, 1'b1, 4'b0000},
    '{4'b0010, 4'b0001, 4'b1111, 4'b0010, 1'b1, 4'b0001},
    '{4'b0001, 4'b0000, 4'b1111, 4'b0010, 1'b1, 4'b1000}
  };
  string row_names [ROWS] = '{
    "unicast_lane1", "unicast_lane2", "multicast_wait", "forward_uplink",
    "forward_off_lanes", "drop_a", "drop_b", "moved_local_bundle", "forward_empty_lane"
  };

  request_router_top dut (
    .ap_clk        (ap_clk),
    .areset_control(areset_control),
    .request_in    (request_in),
    .request_status(request_status),
    .request_out   (request_out),
    .dest_ready    (dest_ready),
    .cfg_req       (cfg_req),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_ack       (cfg_ack),
    .cfg_rdata     (cfg_rdata)
  );

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Checks failed");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  // Inputs change and outputs are read just after the rising edge
  task automatic next_cycle();
    @(posedge ap_clk);
    #2;
  endtask

  function automatic logic [N-1:0] port_valids();
    logic [N-1:0] mask;
    for (int i = 0; i < N; i++) begin
      mask[i] = request_out[i].valid;
    end
    return mask;
  endfunction

  // --------------------
  // Config port driver
  // --------------------

  task automatic cfg_access(input logic we, input fifo_pkg::cfg_addr_e addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    check_value("ack low before req", 128'(1'b0), 128'(cfg_ack));
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    cycles    = 0;
    next_cycle();
    while (!cfg_ack) begin
      if (cycles == TIMEOUT) abort_run("Timed out waiting for config ack to rise");
      next_cycle();
      cycles++;
    end
    rdata = cfg_rdata;
    // Ack must hold while req stays up
    next_cycle();
    check_value("ack held while req high", 128'(1'b1), 128'(cfg_ack));
    cfg_req = 1'b0;
    cycles  = 0;
    next_cycle();
    while (cfg_ack) begin
      if (cycles == TIMEOUT) abort_run("Timed out waiting for config ack to fall");
      next_cycle();
      cycles++;
    end
    cfg_we = 1'b0;
  endtask

  task automatic set_routing(input logic [N-1:0] local_id, input logic fwd);
    logic [31:0] rdata;
    cfg_access(1'b1, fifo_pkg::LOCAL_BUNDLE, 32'(local_id), rdata);
    cfg_access(1'b1, fifo_pkg::FORWARD_EN, 32'(fwd), rdata);
    cfg_access(1'b0, fifo_pkg::LOCAL_BUNDLE, '0, rdata);
    check_value("read LOCAL_BUNDLE", 128'(local_id), 128'(rdata));
    cfg_access(1'b0, fifo_pkg::FORWARD_EN, '0, rdata);
    check_value("read FORWARD_EN", 128'(fwd), 128'(rdata));
  endtask

  // --------------------
  // Request side
  // --------------------

  task automatic make_payload(input logic [N-1:0] bundle, input logic [N-1:0] lane,
                              output pkt_pkg::payload_t p);
    logic [31:0] bits;
    p.route.bundle = bundle;
    p.route.lane   = lane;
    take_bits(1, bits);
    p.cmd = pkt_pkg::mem_cmd_e'(bits[0]);
    take_bits(32, bits);
    p.addr = bits;
    take_bits(32, bits);
    p.data = bits;
  endtask

  task automatic expect_quiet(input string name, input int ncycles);
    for (int i = 0; i < ncycles; i++) begin
      next_cycle();
      check_value({name, " no output"}, '0, 128'(port_valids()));
    end
  endtask

  // Multicast copies must carry the same payload on every port
  task automatic wait_output(input string name, output logic [N-1:0] mask,
                             output pkt_pkg::payload_t payload);
    int   cycles;
    logic found;
    mask   = '0;
    cycles = 0;
    while (mask == '0) begin
      if (cycles == TIMEOUT) abort_run($sformatf("Timed out waiting for output of %s", name));
      next_cycle();
      cycles++;
      mask = port_valids();
    end
    found   = 1'b0;
    payload = '0;
    for (int i = 0; i < N; i++) begin
      if (mask[i] && !found) begin
        payload = request_out[i].payload;
        found   = 1'b1;
      end else if (mask[i]) begin
        check_value({name, " copy payload"}, 128'(payload), 128'(request_out[i].payload));
      end
    end
  endtask

  task automatic apply_row(input row_t row, input string name);
    pkt_pkg::payload_t sent;
    pkt_pkg::payload_t got;
    logic [N-1:0]      mask;
    logic              stall;
    set_routing(row.local_id, row.fwd);
    dest_ready = row.ready;
    make_payload(row.bundle, row.lane, sent);
    // Lane delivery with a named lane not ready has to wait
    stall = (row.exp_mask == row.lane) && ((row.ready & row.lane) != row.lane);
    request_in.valid   = 1'b1;
    request_in.payload = sent;
    next_cycle();
    request_in.valid = 1'b0;
    if (row.exp_mask == '0) begin
      expected_drops++;
      expect_quiet(name, 8);
    end else begin
      if (stall) begin
        expect_quiet(name, 8);
        dest_ready = '1;
      end
      wait_output(name, mask, got);
      check_value({name, " ports"}, 128'(row.exp_mask), 128'(mask));
      check_value({name, " payload"}, 128'(sent), 128'(got));
    end
  endtask

  task automatic check_arrival_order();
    pkt_pkg::payload_t sent [3];
    pkt_pkg::payload_t got;
    logic [N-1:0]      mask;
    set_routing(N'(1), 1'b0);
    dest_ready = '0;
    for (int k = 0; k < 3; k++) begin
      make_payload(N'(1), N'(1) << k, sent[k]);
    end
    for (int k = 0; k < 3; k++) begin
      request_in.valid   = 1'b1;
      request_in.payload = sent[k];
      next_cycle();
    end
    request_in.valid = 1'b0;
    expect_quiet("queued", 4);
    // Three queued requests, well under the threshold
    check_value("queued status", '0, 128'(request_status));
    dest_ready = '1;
    for (int k = 0; k < 3; k++) begin
      wait_output("queued", mask, got);
      check_value($sformatf("queued %0d ports", k), 128'(N'(1) << k), 128'(mask));
      check_value($sformatf("queued %0d payload", k), 128'(sent[k]), 128'(got));
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    logic [31:0]           rdata;
    int                    cycles;
    fifo_pkg::fifo_state_t idle_status;
    request_in     = '0;
    dest_ready     = '0;
    cfg_req        = 1'b0;
    cfg_we         = 1'b0;
    cfg_addr       = fifo_pkg::LOCAL_BUNDLE;
    cfg_wdata      = '0;
    lfsr_state     = 16'd26;
    expected_drops = 0;
    areset_control = 1'b1;
    repeat (2) next_cycle();
    areset_control = 1'b0;
    check_value("reset valids", '0, 128'(port_valids()));
    check_value("reset ack", 128'(1'b0), 128'(cfg_ack));
    check_value("setup after reset", 128'(1'b1), 128'(request_status.setup));
    cycles = 0;
    while (request_status.setup) begin
      if (cycles == TIMEOUT) abort_run("Timed out waiting for FIFO setup to fall");
      next_cycle();
      cycles++;
    end
    idle_status       = '0;
    idle_status.empty = 1'b1;
    check_value("idle status", 128'(idle_status), 128'(request_status));
    for (int r = 0; r < ROWS; r++) begin
      apply_row(rows[r], row_names[r]);
    end
    check_arrival_order();
    cfg_access(1'b0, fifo_pkg::DROP_COUNT, '0, rdata);
    check_value("read DROP_COUNT", 128'(expected_drops), 128'(rdata));
    $display("All checks passed");
    $finish;
  end

endmodule : request_router_tb

// ==== request_router_top.f ====
+incdir+hw
hw/fifo_pkg.sv
hw/pkt_pkg.sv
hw/sync_fifo_fwft.sv
hw/request_demux.sv
hw/route_config_regs.sv
hw/request_router_top.sv
testbench/request_router_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the request router testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f request_router_top.f \
  --top-module request_router_tb \
  -o request_router_sim

# $fatal ends the run with a nonzero code, so the log decides the result
./obj_dir/request_router_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "All checks passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
